/* rtl/memDefines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address into main memory
`define ADDR_WIDTH 17

// one entry per address
`define RAM_DEPTH (1 << `ADDR_WIDTH)

// owner codes shown to both clients
`define BUSY_NONE  2'b00
`define BUSY_DATA  2'b01
`define BUSY_FETCH 2'b10

`endif

/* rtl/memPkg.sv */
`include "memDefines.svh"

package memPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [7:0]             byteT;
    typedef logic [31:0]            wordT;

    // legal lengths are 1, 2 and 4
    typedef logic [2:0]             lenT;
    typedef logic [1:0]             busyT;

    typedef enum logic [1:0] {
        ownIdle,
        ownData,
        ownFetch
    } ownerT;

    // byte step inside one access
    typedef enum logic [2:0] {
        stZero,
        stOne,
        stTwo,
        stThree,
        stFour
    } stageT;

endpackage

/* rtl/reqArbiter.sv */
`timescale 1ns/10ps

module reqArbiter (
    input  logic          clk,
    input  logic          rst,
    input  logic          idle,
    input  logic          dataEn,
    input  logic          dataStore,
    input  memPkg::lenT   dataLen,
    input  memPkg::addrT  dataAddr,
    input  memPkg::wordT  dataWdata,
    input  logic          fetchEn,
    input  memPkg::addrT  fetchAddr,
    output memPkg::ownerT owner,
    output memPkg::addrT  accAddr,
    output memPkg::lenT   accLen,
    output logic          accStore,
    output memPkg::wordT  accWdata
);
    import memPkg::*;

    // grant and direction, cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            owner    <= ownIdle;
            accLen   <= '0;
            accStore <= 1'b0;
        end else if (idle) begin
            if (dataEn) begin
                owner    <= ownData;
                accLen   <= dataLen;
                accStore <= dataStore;
            end else if (fetchEn) begin
                // instruction fetch is always a word load
                owner    <= ownFetch;
                accLen   <= lenT'(3'd4);
                accStore <= 1'b0;
            end else begin
                owner    <= ownIdle;
                accLen   <= '0;
                accStore <= 1'b0;
            end
        end
    end

    // address and store data of the granted client
    always_ff @(posedge clk) begin
        if (idle) begin
            if (dataEn) begin
                accAddr  <= dataAddr;
                accWdata <= dataWdata;
            end else begin
                accAddr  <= fetchAddr;
                accWdata <= '0;
            end
        end
    end

    // 3-byte accesses are not supported
    assert property (@(posedge clk) disable iff (rst)
        dataEn |-> (dataLen == 3'd1 || dataLen == 3'd2 || dataLen == 3'd4))
        else $error("reqArbiter: illegal data length %0d", dataLen);

endmodule

/* rtl/byteSequencer.sv */
`timescale 1ns/10ps
`include "memDefines.svh"

module byteSequencer (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          ioBufferFull,
    input  memPkg::ownerT owner,
    input  memPkg::addrT  accAddr,
    input  memPkg::lenT   accLen,
    input  logic          accStore,
    input  memPkg::wordT  accWdata,
    output logic          idle,
    output memPkg::addrT  ramAddr,
    output logic          ramWe,
    output memPkg::byteT  ramWbyte,
    output logic          byteValid,
    output memPkg::stageT byteIndex,
    output logic          lastByte,
    output memPkg::busyT  fetchWait,
    output memPkg::busyT  dataWait
);
    import memPkg::*;

    stageT stage;
    stageT pendIndex;
    stageT lane;
    logic  pendValid;
    logic  pendLast;
    logic  spent;
    logic  freeze;
    logic  active;
    logic  issue;
    logic  lastLane;
    logic  doneNow;
    busyT  busyCode;

    assign freeze = !rdy || ioBufferFull;

    // spent covers the gap cycle after done
    assign active = (owner != ownIdle) && !spent;
    assign idle   = !active && !freeze;

    assign issue    = active && !freeze && (lenT'(stage) != accLen);
    assign lastLane = (lenT'(stage) + 3'd1) == accLen;

    // while frozen keep reading the byte still in flight
    assign lane     = freeze ? pendIndex : stage;
    assign ramAddr  = accAddr + addrT'(lane);
    assign ramWe    = issue && accStore;
    assign ramWbyte = byteT'(accWdata >> {stage, 3'b000});

    always_comb begin
        if (accStore) begin
            // stores report on the write strobe itself
            byteValid = ramWe;
            byteIndex = stage;
            lastByte  = lastLane;
        end else begin
            byteValid = pendValid && !freeze;
            byteIndex = pendIndex;
            lastByte  = pendLast;
        end
    end

    assign doneNow = active && byteValid && lastByte;

    always_comb begin
        busyCode = `BUSY_NONE;
        if (active && !doneNow) begin
            busyCode = (owner == ownFetch) ? `BUSY_FETCH : `BUSY_DATA;
        end
    end

    assign fetchWait = busyCode;
    assign dataWait  = busyCode;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage     <= stZero;
            pendIndex <= stZero;
            pendValid <= 1'b0;
            pendLast  <= 1'b0;
            spent     <= 1'b0;
        end else if (!freeze) begin
            pendValid <= issue && !accStore;
            pendLast  <= lastLane;
            pendIndex <= stage;
            if (doneNow) begin
                stage <= stZero;
                spent <= 1'b1;
            end else if (issue) begin
                stage <= stageT'(stage + 3'd1);
            end else if (idle) begin
                spent <= 1'b0;
            end
        end
    end

    // fetches are granted as loads by the arbiter
    assert property (@(posedge clk) disable iff (rst) !(ramWe && owner == ownFetch))
        else $error("byteSequencer: write strobe during fetch");

    assert property (@(posedge clk) disable iff (rst) lenT'(stage) <= accLen)
        else $error("byteSequencer: stage %0d beyond length %0d", stage, accLen);

endmodule

/* rtl/wordAssembler.sv */
`timescale 1ns/10ps

module wordAssembler (
    input  logic          clk,
    input  logic          rst,
    input  memPkg::ownerT owner,
    input  logic          accStore,
    input  logic          byteValid,
    input  memPkg::stageT byteIndex,
    input  logic          lastByte,
    input  memPkg::byteT  ramRbyte,
    output logic          fetchDone,
    output memPkg::wordT  fetchInst,
    output logic          predEn,
    output memPkg::wordT  predInst,
    output logic          dataDone,
    output memPkg::wordT  dataRdata
);
    import memPkg::*;

    wordT partial;
    wordT assembled;
    logic finish;

    assign finish = byteValid && lastByte;

    // upper lanes of partial stay zero for the zero extension
    assign assembled = partial | (wordT'(ramRbyte) << {byteIndex, 3'b000});

    assign dataDone  = finish && (owner == ownData);
    assign fetchDone = finish && (owner == ownFetch);

    // predictor sees every fetched word
    assign predEn    = fetchDone;
    assign predInst  = assembled;
    assign fetchInst = assembled;

    assign dataRdata = accStore ? '0 : assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            partial <= '0;
        end else if (finish) begin
            partial <= '0;
        end else if (byteValid && !accStore) begin
            partial <= assembled;
        end
    end

    // each access ends in a single done pulse
    assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> !(fetchDone || dataDone))
        else $error("wordAssembler: done pulse in two consecutive cycles");

endmodule

/* rtl/byteRam.sv */
`timescale 1ns/10ps
`include "memDefines.svh"

module byteRam (
    input  logic         clk,
    input  memPkg::addrT addr,
    input  logic         we,
    input  memPkg::byteT wbyte,
    output memPkg::byteT rbyte
);
    import memPkg::*;

    byteT mem [0:`RAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wbyte;
        end
    end

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        rbyte <= mem[addr];
    end

endmodule

/* rtl/memCtrlTop.sv */
`timescale 1ns/10ps

module memCtrlTop (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         ioBufferFull,
    input  logic         fetchEn,
    input  memPkg::addrT fetchAddr,
    input  logic         dataEn,
    input  logic         dataStore,
    input  memPkg::lenT  dataLen,
    input  memPkg::addrT dataAddr,
    input  memPkg::wordT dataWdata,
    output logic         fetchDone,
    output memPkg::wordT fetchInst,
    output logic         predEn,
    output memPkg::wordT predInst,
    output logic         dataDone,
    output memPkg::wordT dataRdata,
    output memPkg::busyT fetchWait,
    output memPkg::busyT dataWait
);
    import memPkg::*;

    logic  idle;
    ownerT owner;
    addrT  accAddr;
    lenT   accLen;
    logic  accStore;
    wordT  accWdata;
    addrT  ramAddr;
    logic  ramWe;
    byteT  ramWbyte;
    byteT  ramRbyte;
    logic  byteValid;
    stageT byteIndex;
    logic  lastByte;

    reqArbiter arbiter (
        .clk(clk), .rst(rst), .idle(idle),
        .dataEn(dataEn), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .owner(owner), .accAddr(accAddr), .accLen(accLen),
        .accStore(accStore), .accWdata(accWdata)
    );

    byteSequencer sequencer (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .owner(owner), .accAddr(accAddr), .accLen(accLen),
        .accStore(accStore), .accWdata(accWdata),
        .idle(idle), .ramAddr(ramAddr), .ramWe(ramWe), .ramWbyte(ramWbyte),
        .byteValid(byteValid), .byteIndex(byteIndex), .lastByte(lastByte),
        .fetchWait(fetchWait), .dataWait(dataWait)
    );

    wordAssembler assembler (
        .clk(clk), .rst(rst), .owner(owner), .accStore(accStore),
        .byteValid(byteValid), .byteIndex(byteIndex), .lastByte(lastByte),
        .ramRbyte(ramRbyte),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .predEn(predEn), .predInst(predInst),
        .dataDone(dataDone), .dataRdata(dataRdata)
    );

    byteRam ram (
        .clk(clk), .addr(ramAddr), .we(ramWe), .wbyte(ramWbyte), .rbyte(ramRbyte)
    );

endmodule

/* tests/memCtrlTb.sv */
`timescale 1ns/10ps
`include "memDefines.svh"

module memCtrlTb;
    import memPkg::*;

    localparam int NUM_DIRECTED = 15;
    localparam int NUM_RANDOM   = 80;
    localparam int CYCLE_LIMIT  = 8 * (NUM_DIRECTED + 8 + NUM_RANDOM) + 200;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    logic fetchEn;
    addrT fetchAddr;
    logic dataEn;
    logic dataStore;
    lenT  dataLen;
    addrT dataAddr;
    wordT dataWdata;
    logic fetchDone;
    wordT fetchInst;
    logic predEn;
    wordT predInst;
    logic dataDone;
    wordT dataRdata;
    busyT fetchWait;
    busyT dataWait;

    logic [31:0] lfsr = 32'h23d5_05eb;
    logic [7:0]  shadow [int];
    wordT        dataExp[$];
    int          dataBase[$];
    logic        dataIsStore[$];
    wordT        fetchExp[$];

    int   cyc = 0;
    int   errors = 0;
    int   passCount = 0;
    int   dataAcc;
    int   fetchAcc;
    int   dataFrz;
    int   fetchFrz;
    int   lastDataDone;
    int   lastFetchDone;
    logic dataOut = 1'b0;
    logic fetchOut = 1'b0;
    logic freezeOn = 1'b0;

    memCtrlTop DUT (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .dataEn(dataEn), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .predEn(predEn), .predInst(predInst),
        .dataDone(dataDone), .dataRdata(dataRdata),
        .fetchWait(fetchWait), .dataWait(dataWait)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // little-endian word with zeros above len bytes
    function automatic wordT expectWord(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(len)) begin
                w[i*8 +: 8] = shadow[int'(addr) + i];
            end
        end
        return w;
    endfunction

    task automatic logError(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic closeTest(input string name, input int errBefore);
        // wait for the compare of the last done pulse
        @(posedge clk);
        if (errors == errBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic doData(input logic store, input lenT len, input addrT addr, input wordT wdata);
        @(posedge clk);
        dataEn    <= 1'b1;
        dataStore <= store;
        dataLen   <= len;
        dataAddr  <= addr;
        dataWdata <= wdata;
        if (store) begin
            for (int i = 0; i < int'(len); i++) begin
                shadow[int'(addr) + i] = wdata[i*8 +: 8];
            end
            dataExp.push_back('0);
            dataBase.push_back(int'(len));
        end else begin
            dataExp.push_back(expectWord(addr, len));
            dataBase.push_back(int'(len) + 1);
        end
        dataIsStore.push_back(store);
        do @(posedge clk); while (!dataDone);
        dataEn <= 1'b0;
    endtask

    task automatic doFetch(input addrT addr);
        @(posedge clk);
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
        fetchExp.push_back(expectWord(addr, 3'd4));
        do @(posedge clk); while (!fetchDone);
        fetchEn <= 1'b0;
    endtask

    // random chip stalls
    always @(posedge clk) begin
        if (freezeOn) begin
            rdy          <= (randBits(3) != 32'd0);
            ioBufferFull <= (randBits(3) == 32'd0);
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    // compare done pulses, latency and busy codes
    always @(posedge clk) begin
        logic frozen;
        busyT expBusy;
        wordT e;
        int   base;
        logic st;
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end else if (!rst) begin
            frozen = !rdy || ioBufferFull;
            if ((dataDone || fetchDone) && frozen) begin
                logError("done pulse while frozen");
            end
            expBusy = `BUSY_NONE;
            if (!dataDone && !fetchDone) begin
                if (dataOut) begin
                    expBusy = `BUSY_DATA;
                end else if (fetchOut) begin
                    expBusy = `BUSY_FETCH;
                end
            end
            if (dataWait != expBusy || fetchWait != expBusy) begin
                logError($sformatf("busy %0d/%0d, expected %0d", dataWait, fetchWait, expBusy));
            end
            if (predEn != fetchDone) begin
                logError("predEn differs from fetchDone");
            end
            if (dataDone) begin
                if (!dataOut || dataExp.size() == 0) begin
                    logError("dataDone with no data access running");
                end else begin
                    e    = dataExp.pop_front();
                    base = dataBase.pop_front();
                    st   = dataIsStore.pop_front();
                    if (!st && dataRdata != e) begin
                        logError($sformatf("dataRdata %h, expected %h", dataRdata, e));
                    end
                    if (cyc != dataAcc + base + dataFrz) begin
                        logError($sformatf("data latency %0d, expected %0d",
                            cyc - dataAcc, base + dataFrz));
                    end
                    dataOut      = 1'b0;
                    lastDataDone = cyc;
                end
            end else if (dataOut && frozen) begin
                dataFrz++;
            end
            if (fetchDone) begin
                if (!fetchOut || fetchExp.size() == 0) begin
                    logError("fetchDone with no fetch running");
                end else begin
                    e = fetchExp.pop_front();
                    if (fetchInst != e || predInst != e) begin
                        logError($sformatf("fetch %h pred %h, expected %h",
                            fetchInst, predInst, e));
                    end
                    if (cyc != fetchAcc + 5 + fetchFrz) begin
                        logError($sformatf("fetch latency %0d, expected %0d",
                            cyc - fetchAcc, 5 + fetchFrz));
                    end
                    fetchOut      = 1'b0;
                    lastFetchDone = cyc;
                end
            end else if (fetchOut && frozen) begin
                fetchFrz++;
            end
            // data wins when both ask at an idle edge
            if (DUT.idle) begin
                if (dataEn) begin
                    dataOut = 1'b1;
                    dataAcc = cyc;
                    dataFrz = 0;
                end else if (fetchEn) begin
                    fetchOut = 1'b1;
                    fetchAcc = cyc;
                    fetchFrz = 0;
                end
            end
        end
    end

    initial begin
        int          errBefore;
        logic [31:0] r;
        addrT        words [8];
        addrT        w;
        lenT         len;
        logic [1:0]  offs;
        logic [1:0]  op;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = 3'd1;
        dataAddr     = '0;
        dataWdata    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // outputs straight after reset
        errBefore = errors;
        if (dataDone || fetchDone || predEn || DUT.ramWe) begin
            logError("strobe high after reset");
        end
        if (dataWait != `BUSY_NONE || fetchWait != `BUSY_NONE) begin
            logError("busy code not idle after reset");
        end

        begin
            int e1;
            e1 = errors;
            doData(1'b1, 3'd1, 17'h00100, randBits(32));
            doData(1'b1, 3'd2, 17'h00202, randBits(32));
            doData(1'b1, 3'd4, 17'h00304, randBits(32));
            doData(1'b0, 3'd1, 17'h00100, '0);
            doData(1'b0, 3'd2, 17'h00202, '0);
            doData(1'b0, 3'd4, 17'h00304, '0);
            closeTest("store and load", e1);

            e1 = errors;
            doData(1'b1, 3'd4, 17'h01000, randBits(32));
            doFetch(17'h01000);
            closeTest("fetch", e1);

            e1 = errors;
            doData(1'b1, 3'd4, 17'h02000, randBits(32));
            doData(1'b1, 3'd4, 17'h02010, randBits(32));
            fork
                doData(1'b0, 3'd4, 17'h02000, '0);
                doFetch(17'h02010);
            join
            @(posedge clk);
            if (lastDataDone >= lastFetchDone) begin
                logError("fetch finished before the data access that arrived with it");
            end
            fork
                doFetch(17'h02000);
                begin
                    repeat (2) @(posedge clk);
                    doData(1'b0, 3'd2, 17'h02010, '0);
                end
            join
            @(posedge clk);
            if (lastFetchDone >= lastDataDone) begin
                logError("running fetch was overtaken by a data access");
            end
            closeTest("priority", e1);
        end

        doData(1'b0, 3'd4, 17'h00304, '0);
        closeTest("busy codes", errBefore);

        errBefore = errors;
        freezeOn <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            r        = randBits(15);
            words[i] = {r[14:0], 2'b00};
            doData(1'b1, 3'd4, words[i], randBits(32));
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r  = randBits(3);
            w  = words[r[2:0]];
            op = 2'(randBits(2));
            r  = randBits(2);
            if (r[1:0] == 2'd0) begin
                len = 3'd1;
            end else if (r[1:0] == 2'd1) begin
                len = 3'd2;
            end else begin
                len = 3'd4;
            end
            // naturally aligned inside the word
            offs = 2'(randBits(2));
            if (len == 3'd4) begin
                offs = 2'd0;
            end else if (len == 3'd2) begin
                offs = offs & 2'b10;
            end
            if (op == 2'd0) begin
                doFetch(w);
            end else if (op == 2'd1) begin
                doData(1'b1, len, w + addrT'(offs), randBits(32));
            end else begin
                doData(1'b0, len, w + addrT'(offs), '0);
            end
        end
        freezeOn <= 1'b0;
        repeat (4) @(posedge clk);
        if (dataExp.size() != 0 || fetchExp.size() != 0) begin
            logError("requests left without a done pulse");
        end
        closeTest("random with freeze", errBefore);

        $display("tests passed %0d of 5, errors %0d", passCount, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/memPkg.sv
rtl/reqArbiter.sv
rtl/byteSequencer.sv
rtl/wordAssembler.sv
rtl/byteRam.sv
rtl/memCtrlTop.sv
tests/memCtrlTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module memCtrlTb -o memCtrlSim

output=$(./obj_dir/memCtrlSim || true)
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
fi
exit 1
